//--- design/fir_params.svh
// FIR filter configuration macros for widths, tap count and output scaling
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// Width of the input and output samples
`define FIR_DATA_WIDTH 16

// Width of the coefficients, which are Q1.15
`define FIR_TAP_WIDTH 16

// Maximum number of taps and depth of both RAMs, a power of two
`define FIR_MAX_TAPS 16

// Address width of the tap RAM and of the delay line
`define FIR_ADDR_WIDTH 4

// Accumulator width, with headroom for 16 full-scale products
`define FIR_ACC_WIDTH 40

// Arithmetic right shift from the accumulator to the output sample
`define FIR_OUT_SHIFT 15

// Width of the routing tag carried with each sample
`define FIR_DEST_WIDTH 8

`endif

//--- design/fir_pkg.sv
// FIR filter package with the data, coefficient, accumulator and index types
`default_nettype none

`include "fir_params.svh"

package fir_pkg;

    // Signed sample word on the input and output streams
    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;

    // Signed Q1.15 coefficient word
    typedef logic signed [`FIR_TAP_WIDTH-1:0] tap_t;

    // Accumulator of the multiply-accumulate datapath
    typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

    // Address of both RAMs, also used as the tap index
    typedef logic [`FIR_ADDR_WIDTH-1:0] addr_t;

    // Number of valid history samples, from 0 up to the RAM depth
    typedef logic [`FIR_ADDR_WIDTH:0] count_t;

    // Routing tag that follows a sample through the filter
    typedef logic [`FIR_DEST_WIDTH-1:0] dest_t;

endpackage

`default_nettype wire

//--- design/dual_port_ram.sv
// Simple dual-port RAM with one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module dual_port_ram #(
    parameter type word_t = logic [15:0]
) (
    input  logic           clock,

    // Write port
    input  fir_pkg::addr_t waddr,
    input  word_t          wdata,
    input  logic           we,

    // Read port, data returns one cycle after the address
    input  fir_pkg::addr_t raddr,
    output word_t          rdata
);

    // One word per tap position
    word_t memory [`FIR_MAX_TAPS];

    always_ff @(posedge clock) begin
        if (we) begin
            memory[waddr] <= wdata;
        end
    end

    // The read samples the array before this edge's write lands, so a word
    // written at one edge is seen by a read addressed at the next edge
    always_ff @(posedge clock) begin
        rdata <= memory[raddr];
    end

    // A write to an unknown address would corrupt an unknown word
    property p_write_addr_known;
        @(posedge clock) we |-> !$isunknown(waddr);
    endproperty

    a_write_addr_known: assert property (p_write_addr_known)
        else $error("RAM write with unknown address");

endmodule

`default_nettype wire

//--- design/fir_filter_serial.sv
// Serial FIR core with one multiplier, circular delay line and writable taps
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module fir_filter_serial (
    input  logic             clock,
    input  logic             reset,

    // Configuration and tap load
    input  fir_pkg::addr_t   n_taps,
    input  fir_pkg::addr_t   tap_addr,
    input  fir_pkg::tap_t    tap_data,
    input  logic             tap_write,

    // Input stream
    input  fir_pkg::sample_t in_data,
    input  fir_pkg::dest_t   in_dest,
    input  logic             in_valid,
    output logic             in_ready,

    // Output stream
    output fir_pkg::sample_t out_data,
    output fir_pkg::dest_t   out_dest,
    output logic             out_valid,
    input  logic             out_ready
);

    typedef enum logic [1:0] {
        state_idle,
        state_run,
        state_hold
    } state_t;

    state_t state;

    logic accept;

    // Pointer to the newest sample in the delay line
    fir_pkg::addr_t write_ptr;

    // Number of samples written since reset, saturating at the depth
    fir_pkg::count_t fill_count;

    // Address stage of the MAC pipeline
    fir_pkg::addr_t tap_index;
    logic           issuing;

    // Data stage, aligned with the RAM read data
    fir_pkg::addr_t tap_index_d;
    logic           term_valid_d;
    logic           mac_en;

    // Set for one cycle after the last product has been accumulated
    logic acc_done;

    fir_pkg::acc_t acc;

    fir_pkg::tap_t    tap_rdata;
    fir_pkg::sample_t sample_rdata;
    fir_pkg::addr_t   delay_raddr;

    logic signed [2*`FIR_DATA_WIDTH-1:0] product;
    fir_pkg::acc_t                       term_product;

    assign accept = in_valid && in_ready;

    // Newest sample sits at write_ptr, older ones at decreasing addresses
    assign delay_raddr = write_ptr - tap_index;

    dual_port_ram #(
        .word_t (fir_pkg::tap_t)
    ) tap_memory (
        .clock (clock),
        .waddr (tap_addr),
        .wdata (tap_data),
        .we    (tap_write),
        .raddr (tap_index),
        .rdata (tap_rdata)
    );

    dual_port_ram #(
        .word_t (fir_pkg::sample_t)
    ) delay_line (
        .clock (clock),
        .waddr (write_ptr + 1'b1),
        .wdata (in_data),
        .we    (accept),
        .raddr (delay_raddr),
        .rdata (sample_rdata)
    );

    assign product = tap_rdata * sample_rdata;

    // Terms reaching back past the first sample since reset read stale RAM words
    assign term_product = term_valid_d ? fir_pkg::acc_t'(product) : '0;

    // Control state and handshake flags
    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= state_idle;
            in_ready   <= 1'b1;
            out_valid  <= 1'b0;
            write_ptr  <= '0;
            fill_count <= '0;
            issuing    <= 1'b0;
            mac_en     <= 1'b0;
            acc_done   <= 1'b0;
        end else begin
            mac_en   <= 1'b0;
            acc_done <= 1'b0;
            case (state)
                state_idle: begin
                    if (accept) begin
                        state     <= state_run;
                        in_ready  <= 1'b0;
                        issuing   <= 1'b1;
                        write_ptr <= write_ptr + 1'b1;
                        if (fill_count != `FIR_MAX_TAPS) begin
                            fill_count <= fill_count + 1'b1;
                        end
                    end
                end
                state_run: begin
                    mac_en <= issuing;
                    if (issuing && tap_index == n_taps) begin
                        issuing <= 1'b0;
                    end
                    acc_done <= mac_en && tap_index_d == n_taps;
                    if (acc_done) begin
                        state     <= state_hold;
                        out_valid <= 1'b1;
                    end
                end
                state_hold: begin
                    // Result is held until the sink takes it
                    if (out_ready) begin
                        state     <= state_idle;
                        out_valid <= 1'b0;
                        in_ready  <= 1'b1;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // Tap index, MAC datapath and output register
    always_ff @(posedge clock) begin
        if (accept) begin
            tap_index <= '0;
            acc       <= '0;
            out_dest  <= in_dest;
        end else if (state == state_run) begin
            if (issuing && tap_index != n_taps) begin
                tap_index <= tap_index + 1'b1;
            end
            tap_index_d  <= tap_index;
            term_valid_d <= fir_pkg::count_t'(tap_index) < fill_count;
            if (mac_en) begin
                acc <= acc + term_product;
            end
            if (acc_done) begin
                out_data <= fir_pkg::sample_t'(acc >>> `FIR_OUT_SHIFT);
            end
        end
    end

    // A stalled result must not change under the sink
    property p_output_stable;
        @(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_data) && $stable(out_dest);
    endproperty

    a_output_stable: assert property (p_output_stable)
        else $error("Output changed while stalled");

    // Only one sample is in flight, so input and output never overlap
    property p_one_in_flight;
        @(posedge clock) disable iff (reset)
        !(in_ready && out_valid);
    endproperty

    a_one_in_flight: assert property (p_one_in_flight)
        else $error("in_ready and out_valid high together");

endmodule

`default_nettype wire

//--- design/fir_subsystem.sv
// FIR subsystem top level exposing the sample streams and the tap-load port
`timescale 1ns/1ps
`default_nettype none

module fir_subsystem (
    input  logic             clock,
    input  logic             reset,

    // Configuration and tap load
    input  fir_pkg::addr_t   n_taps,
    input  fir_pkg::addr_t   tap_addr,
    input  fir_pkg::tap_t    tap_data,
    input  logic             tap_write,

    // Input stream
    input  fir_pkg::sample_t in_data,
    input  fir_pkg::dest_t   in_dest,
    input  logic             in_valid,
    output logic             in_ready,

    // Output stream
    output fir_pkg::sample_t out_data,
    output fir_pkg::dest_t   out_dest,
    output logic             out_valid,
    input  logic             out_ready
);

    // Single serial core, one computation in flight at a time
    fir_filter_serial i_core (
        .clock     (clock),
        .reset     (reset),
        .n_taps    (n_taps),
        .tap_addr  (tap_addr),
        .tap_data  (tap_data),
        .tap_write (tap_write),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- tb/fir_subsystem_tb.sv
// Testbench for the FIR subsystem with random stimulus checked against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "fir_params.svh"

module fir_subsystem_tb;

    localparam int timeout_cycles = 200;

    logic             clock;
    logic             reset;
    fir_pkg::addr_t   n_taps;
    fir_pkg::addr_t   tap_addr;
    fir_pkg::tap_t    tap_data;
    logic             tap_write;
    fir_pkg::sample_t in_data;
    fir_pkg::dest_t   in_dest;
    logic             in_valid;
    logic             in_ready;
    fir_pkg::sample_t out_data;
    fir_pkg::dest_t   out_dest;
    logic             out_valid;
    logic             out_ready;

    integer seed;
    logic   random_ready;
    string  test_name;

    // Reference model state
    fir_pkg::tap_t    tap_model [`FIR_MAX_TAPS];
    fir_pkg::sample_t history [`FIR_MAX_TAPS];
    int               history_ptr;
    int               history_fill;
    fir_pkg::sample_t expected_data [$];
    fir_pkg::dest_t   expected_dest [$];

    // Monitor bookkeeping
    longint cycle;
    longint accept_cycle;
    logic   prev_out_valid;
    logic   busy;

    fir_subsystem i_dut (
        .clock     (clock),
        .reset     (reset),
        .n_taps    (n_taps),
        .tap_addr  (tap_addr),
        .tap_data  (tap_data),
        .tap_write (tap_write),
        .in_data   (in_data),
        .in_dest   (in_dest),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #2 clock = ~clock;

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: %s did not happen within %0d cycles", what, timeout_cycles);
        abort_run();
    endtask

    task automatic clear_model();
        foreach (history[i]) begin
            history[i] = '0;
        end
        history_ptr = 0;
        history_fill = 0;
        expected_data.delete();
        expected_dest.delete();
        busy = 1'b0;
        prev_out_valid = 1'b0;
    endtask

    // Sum of tap[k] * x[n-k] over the active taps, with terms before the first
    // sample since reset counted as zero
    task automatic model_accept(input fir_pkg::sample_t data, input fir_pkg::dest_t dest);
        longint sum;
        int     k;
        int     slot;
        history_ptr = (history_ptr + 1) % `FIR_MAX_TAPS;
        history[history_ptr] = data;
        if (history_fill < `FIR_MAX_TAPS) begin
            history_fill++;
        end
        sum = 0;
        for (k = 0; k <= int'(n_taps); k++) begin
            if (k < history_fill) begin
                slot = (history_ptr - k + `FIR_MAX_TAPS) % `FIR_MAX_TAPS;
                sum += longint'(tap_model[k]) * longint'(history[slot]);
            end
        end
        expected_data.push_back(fir_pkg::sample_t'(sum >>> `FIR_OUT_SHIFT));
        expected_dest.push_back(dest);
    endtask

    // Watches both streams at each rising edge, before the DUT registers update
    always @(posedge clock) begin
        cycle = cycle + 1;
        if (reset) begin
            clear_model();
        end else begin
            if (busy) begin
                check_value({test_name, " in_ready while busy"}, 0, in_ready);
            end
            if (out_valid && !prev_out_valid) begin
                // First seen one edge after the edge that raised it
                check_value({test_name, " latency"}, int'(n_taps) + 3,
                            cycle - 1 - accept_cycle);
            end
            if (in_valid && in_ready) begin
                model_accept(in_data, in_dest);
                accept_cycle = cycle;
                busy = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (expected_data.size() == 0) begin
                    $display("ERROR: output transfer with no sample in flight");
                    abort_run();
                end else begin
                    check_value({test_name, " data"}, expected_data.pop_front(), out_data);
                    check_value({test_name, " dest"}, expected_dest.pop_front(), out_dest);
                    busy = 1'b0;
                end
            end
            prev_out_valid = out_valid;
        end
    end

    // Random back-pressure from the sink
    always @(posedge clock) begin
        #0.5;
        if (random_ready) begin
            out_ready = 1'($random(seed));
        end
    end

    task automatic send_sample(input fir_pkg::sample_t data, input fir_pkg::dest_t dest);
        int waited;
        waited = 0;
        in_data = data;
        in_dest = dest;
        in_valid = 1'b1;
        @(posedge clock);
        while (!in_ready) begin
            if (waited == timeout_cycles) begin
                report_timeout("input handshake (in_ready high)");
            end else begin
                waited++;
                @(posedge clock);
            end
        end
        #0.5;
        in_valid = 1'b0;
    endtask

    task automatic stream_random(input int count);
        int i;
        for (i = 0; i < count; i++) begin
            send_sample(fir_pkg::sample_t'($random(seed)), fir_pkg::dest_t'($random(seed)));
        end
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!(in_ready && !out_valid)) begin
            if (waited == timeout_cycles) begin
                report_timeout("return of the core to idle");
            end else begin
                waited++;
                @(posedge clock);
                #0.5;
            end
        end
    endtask

    task automatic load_taps();
        int a;
        wait_idle();
        for (a = 0; a < `FIR_MAX_TAPS; a++) begin
            tap_model[a] = fir_pkg::tap_t'($random(seed));
            tap_addr = fir_pkg::addr_t'(a);
            tap_data = tap_model[a];
            tap_write = 1'b1;
            @(posedge clock);
            #0.5;
        end
        tap_write = 1'b0;
    endtask

    // Once the core is idle again, every accepted sample must have left with its result
    task automatic finish_phase();
        wait_idle();
        check_value({test_name, " results pending"}, 0, expected_data.size());
    endtask

    task automatic apply_reset();
        in_valid = 1'b0;
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #0.5;
        reset = 1'b0;
    endtask

    initial begin
        int i;
        seed = 21;
        clock = 1'b0;
        reset = 1'b1;
        n_taps = 4'd15;
        tap_addr = '0;
        tap_data = '0;
        tap_write = 1'b0;
        in_data = '0;
        in_dest = '0;
        in_valid = 1'b0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        cycle = 0;
        accept_cycle = 0;
        foreach (tap_model[i]) begin
            tap_model[i] = '0;
        end
        clear_model();

        test_name = "reset_state";
        apply_reset();
        check_value({test_name, " in_ready"}, 1, in_ready);
        check_value({test_name, " out_valid"}, 0, out_valid);

        // A full-scale impulse reproduces the scaled taps in order
        test_name = "impulse";
        load_taps();
        send_sample(16'h7FFF, 8'h01);
        for (i = 0; i < 15; i++) begin
            send_sample('0, fir_pkg::dest_t'(i + 2));
        end
        finish_phase();

        test_name = "random_stream";
        stream_random(200);
        finish_phase();

        // History from the previous stream carries over
        test_name = "reconfig";
        load_taps();
        n_taps = 4'd4;
        stream_random(100);
        finish_phase();

        test_name = "backpressure";
        random_ready = 1'b1;
        stream_random(150);
        finish_phase();
        random_ready = 1'b0;
        out_ready = 1'b1;

        // Reset lands in the run state, then stale RAM words must stay masked
        test_name = "reset_midstream";
        send_sample(fir_pkg::sample_t'($random(seed)), 8'hA5);
        @(posedge clock);
        #0.5;
        apply_reset();
        check_value({test_name, " in_ready"}, 1, in_ready);
        check_value({test_name, " out_valid"}, 0, out_valid);
        n_taps = 4'd15;
        stream_random(60);
        finish_phase();

        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+design
design/fir_pkg.sv
design/dual_port_ram.sv
design/fir_filter_serial.sv
design/fir_subsystem.sv
tb/fir_subsystem_tb.sv

//--- Bender.yml
package:
  name: fir_subsystem

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/fir_pkg.sv
      - design/dual_port_ram.sv
      - design/fir_filter_serial.sv
      - design/fir_subsystem.sv

  - target: simulation
    include_dirs:
      - design
    files:
      - tb/fir_subsystem_tb.sv
